// ==== rtl/dupmem_pkg.sv ====
package dupmem_pkg;

  localparam int DATA_W = 16;
  localparam int ADDR_W = 7;
  localparam int ROW_W  = 4;
  localparam int BANK_W = 3;
  localparam int PADR_W = BANK_W + ROW_W; // Bank in the upper bits, row in the lower.

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } wr_req_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
    logic [PADR_W-1:0] padr;
  } rd_rsp_t;

  // One command per bank copy. Read and write are never set together.
  typedef struct packed {
    logic              read;
    logic              write;
    logic [ROW_W-1:0]  row;
    logic [DATA_W-1:0] data;
  } bank_cmd_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [ROW_W-1:0]  row;
  } bank_rsp_t;

endpackage

// ==== rtl/np2_addr.sv ====
`timescale 1ns/1ps

// Maps a flat address onto bank and row. Neither the row count nor the
// address count has to be a power of two.
module np2_addr #(
  parameter int NUMVROW = 16,
  parameter int NUMADDR = 96
) (
  input  logic [dupmem_pkg::ADDR_W-1:0] addr,
  output logic [dupmem_pkg::BANK_W-1:0] bank,
  output logic [dupmem_pkg::ROW_W-1:0]  row,
  output logic                          in_range
);

  localparam int AW = dupmem_pkg::ADDR_W;
  localparam logic [AW-1:0] ROWS = AW'(NUMVROW);

  logic [AW-1:0] quot;
  logic [AW-1:0] rem;

  assign quot = addr / ROWS;
  assign rem  = addr % ROWS;

  assign bank = quot[dupmem_pkg::BANK_W-1:0]; // Upper bits only matter when out of range.
  assign row  = rem[dupmem_pkg::ROW_W-1:0];

  assign in_range = (addr < NUMADDR);

endmodule

// ==== rtl/sram_bank.sv ====
`timescale 1ns/1ps

// One copy of one bank. The row of a read is latched on the sampling edge,
// then the array word and the row travel down SRAM_DELAY data stages, so
// the response shows up SRAM_DELAY edges after the read was sampled.
module sram_bank #(
  parameter int NUMVROW    = 16,
  parameter int SRAM_DELAY = 2
) (
  input  logic                  clk,
  input  dupmem_pkg::bank_cmd_t cmd,
  output dupmem_pkg::bank_rsp_t rsp
);

  logic [dupmem_pkg::DATA_W-1:0] mem [NUMVROW];
  logic [dupmem_pkg::ROW_W-1:0]  rd_row_q;
  dupmem_pkg::bank_rsp_t         pipe [SRAM_DELAY];

  always_ff @(posedge clk) begin
    if (cmd.write) begin
      mem[cmd.row] <= cmd.data;
    end
    if (cmd.read) begin
      rd_row_q <= cmd.row; // Address latch, held between reads.
    end
  end

  // The array is read one edge after the latch, so a write on that same
  // edge belongs to a later request and is not seen here.
  always_ff @(posedge clk) begin
    pipe[0].data <= mem[rd_row_q];
    pipe[0].row  <= rd_row_q;
    for (int i = 1; i < SRAM_DELAY; i++) begin
      pipe[i] <= pipe[i-1];
    end
  end

  assign rsp = pipe[SRAM_DELAY-1];

  // The core gives writes priority and drops the reads of that cycle.
  a_rd_wr_excl: assert property (@(posedge clk) !(cmd.read && cmd.write))
    else $error("bank copy got read and write in the same cycle");

endmodule

// ==== rtl/core_nror1w_dup.sv ====
`timescale 1ns/1ps

// Multi-read, single-write controller over duplicated banks. Each read port
// owns one copy of every bank, and a write updates all copies of its bank.
// Copy index is bank * NUMRDPT + port.
module core_nror1w_dup #(
  parameter int NUMRDPT    = 2,
  parameter int NUMVBNK    = 6,
  parameter int NUMVROW    = 16,
  parameter int NUMADDR    = 96,
  parameter int SRAM_DELAY = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  write,
  input  dupmem_pkg::wr_req_t   wreq,
  input  dupmem_pkg::rd_req_t   rreq [NUMRDPT],
  output logic                  ready,
  output dupmem_pkg::rd_rsp_t   rrsp [NUMRDPT],
  output dupmem_pkg::bank_cmd_t bcmd [NUMRDPT*NUMVBNK],
  input  dupmem_pkg::bank_rsp_t brsp [NUMRDPT*NUMVBNK]
);

  localparam int BW = dupmem_pkg::BANK_W;
  localparam int RW = dupmem_pkg::ROW_W;

  logic          wr_in_range;
  logic [BW-1:0] wr_bank;
  logic [RW-1:0] wr_row;
  logic          wr_go;

  logic [NUMRDPT-1:0] rd_in_range;
  logic [BW-1:0]      rd_bank [NUMRDPT];
  logic [RW-1:0]      rd_row [NUMRDPT];
  logic [NUMRDPT-1:0] rd_go;

  // Stage 0 lines up with the row latch of the bank copies, stage k with
  // their data stage k-1.
  logic [SRAM_DELAY:0]         vld_pipe [NUMRDPT];
  logic [SRAM_DELAY:0][BW-1:0] bank_pipe [NUMRDPT];
  logic [NUMRDPT-1:0]          vld_last;

  // Low through reset and the cycle after its last edge, high from the
  // first edge that samples rst low.
  always_ff @(posedge clk) begin
    ready <= !rst;
  end

  np2_addr #(
    .NUMVROW (NUMVROW),
    .NUMADDR (NUMADDR)
  ) wr_adr_i (
    .addr     (wreq.addr),
    .bank     (wr_bank),
    .row      (wr_row),
    .in_range (wr_in_range)
  );

  assign wr_go = ready && write && wr_in_range;

  for (genvar p = 0; p < NUMRDPT; p++) begin : g_rd
    np2_addr #(
      .NUMVROW (NUMVROW),
      .NUMADDR (NUMADDR)
    ) rd_adr_i (
      .addr     (rreq[p].addr),
      .bank     (rd_bank[p]),
      .row      (rd_row[p]),
      .in_range (rd_in_range[p])
    );

    // An accepted write takes every copy, so reads of this cycle are lost.
    assign rd_go[p] = ready && !wr_go && rreq[p].valid && rd_in_range[p];

    assign vld_last[p] = vld_pipe[p][SRAM_DELAY];
  end

  always_comb begin
    for (int b = 0; b < NUMVBNK; b++) begin
      for (int p = 0; p < NUMRDPT; p++) begin
        bcmd[b*NUMRDPT+p].write = wr_go && (wr_bank == BW'(b));
        bcmd[b*NUMRDPT+p].read  = rd_go[p] && (rd_bank[p] == BW'(b));
        bcmd[b*NUMRDPT+p].row   = wr_go ? wr_row : rd_row[p];
        bcmd[b*NUMRDPT+p].data  = wreq.data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < NUMRDPT; p++) begin
        vld_pipe[p] <= '0;
      end
    end else begin
      for (int p = 0; p < NUMRDPT; p++) begin
        vld_pipe[p] <= {vld_pipe[p][SRAM_DELAY-1:0], rd_go[p]};
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < NUMRDPT; p++) begin
      bank_pipe[p] <= {bank_pipe[p][SRAM_DELAY-1:0], rd_bank[p]};
    end
  end

  // Each port picks its own copy of the bank it read.
  always_comb begin
    for (int p = 0; p < NUMRDPT; p++) begin
      rrsp[p].valid = vld_last[p];
      rrsp[p].data  = '0;
      rrsp[p].padr  = '0;
      for (int b = 0; b < NUMVBNK; b++) begin
        if (bank_pipe[p][SRAM_DELAY] == BW'(b)) begin
          rrsp[p].data = brsp[b*NUMRDPT+p].data;
          rrsp[p].padr = {bank_pipe[p][SRAM_DELAY], brsp[b*NUMRDPT+p].row};
        end
      end
    end
  end

  a_geometry: assert property (@(posedge clk) NUMVBNK * NUMVROW >= NUMADDR)
    else $error("banks times rows do not cover NUMADDR");

  a_widths: assert property (@(posedge clk) NUMVBNK <= 2**BW && NUMVROW <= 2**RW)
    else $error("bank or row count does not fit its index width");

  // Reads wait for ready, which rises one edge after reset ends, so nothing
  // can come back until SRAM_DELAY+2 edges after a reset edge.
  a_rst_quiet: assert property (@(posedge clk) rst |-> ##(SRAM_DELAY+2) !(|vld_last))
    else $error("read response valid too soon after a reset cycle");

endmodule

// ==== rtl/dupmem_top.sv ====
`timescale 1ns/1ps

// Multi-read, single-write memory built from NUMRDPT copies of every bank.
module dupmem_top #(
  parameter int NUMRDPT    = 2,
  parameter int NUMVBNK    = 6,
  parameter int NUMVROW    = 16,
  parameter int NUMADDR    = 96,
  parameter int SRAM_DELAY = 2
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                write,
  input  dupmem_pkg::wr_req_t wreq,
  input  dupmem_pkg::rd_req_t rreq [NUMRDPT],
  output logic                ready,
  output dupmem_pkg::rd_rsp_t rrsp [NUMRDPT]
);

  dupmem_pkg::bank_cmd_t bcmd [NUMRDPT*NUMVBNK];
  dupmem_pkg::bank_rsp_t brsp [NUMRDPT*NUMVBNK];

  core_nror1w_dup #(
    .NUMRDPT    (NUMRDPT),
    .NUMVBNK    (NUMVBNK),
    .NUMVROW    (NUMVROW),
    .NUMADDR    (NUMADDR),
    .SRAM_DELAY (SRAM_DELAY)
  ) core_i (
    .clk   (clk),
    .rst   (rst),
    .write (write),
    .wreq  (wreq),
    .rreq  (rreq),
    .ready (ready),
    .rrsp  (rrsp),
    .bcmd  (bcmd),
    .brsp  (brsp)
  );

  // Copy c serves bank c / NUMRDPT for read port c % NUMRDPT.
  for (genvar c = 0; c < NUMRDPT * NUMVBNK; c++) begin : g_copy
    sram_bank #(
      .NUMVROW    (NUMVROW),
      .SRAM_DELAY (SRAM_DELAY)
    ) bank_i (
      .clk (clk),
      .cmd (bcmd[c]),
      .rsp (brsp[c])
    );
  end

endmodule

// ==== testbench/dupmem_table.svh ====
`ifndef DUPMEM_TABLE_SVH
`define DUPMEM_TABLE_SVH

localparam logic DS_RAND = 1'b0; // Write data taken from the LFSR.
localparam logic DS_ADDR = 1'b1; // Write data built from the write address.

typedef struct packed {
  logic [3:0]                    test_id;
  logic                          wr;
  logic [dupmem_pkg::ADDR_W-1:0] waddr;
  logic                          dsel;
  logic                          rv0;
  logic [dupmem_pkg::ADDR_W-1:0] ra0;
  logic                          dr0;
  logic                          rv1;
  logic [dupmem_pkg::ADDR_W-1:0] ra1;
  logic                          dr1;
} step_t;

localparam int NSTEPS = 33;

// Each row holds the test id, write strobe, write address and data select,
// then for each read port its valid, its address and whether the read must be dropped.
localparam step_t STEPS [NSTEPS] = '{
  '{1, 0,   0, DS_RAND, 1,   0, 1, 1,  17, 1}, // Issued while ready is still low.
  '{2, 1,   0, DS_RAND, 0,   0, 0, 0,   0, 0},
  '{2, 1,  17, DS_RAND, 0,   0, 0, 0,   0, 0},
  '{2, 1,  34, DS_RAND, 0,   0, 0, 0,   0, 0},
  '{2, 1,  51, DS_RAND, 0,   0, 0, 0,   0, 0},
  '{2, 1,  68, DS_RAND, 0,   0, 0, 0,   0, 0},
  '{2, 1,  95, DS_RAND, 0,   0, 0, 0,   0, 0}, // Row 15 of bank 5.
  '{2, 1,   5, DS_RAND, 0,   0, 0, 0,   0, 0},
  '{2, 1,  90, DS_RAND, 0,   0, 0, 0,   0, 0},
  '{2, 0,   0, DS_RAND, 1,   0, 0, 1,   0, 0},
  '{2, 0,   0, DS_RAND, 1,  17, 0, 1,  17, 0},
  '{2, 0,   0, DS_RAND, 1,  34, 0, 1,  34, 0},
  '{2, 0,   0, DS_RAND, 1,  51, 0, 1,  51, 0},
  '{2, 0,   0, DS_RAND, 1,  68, 0, 1,  68, 0},
  '{2, 0,   0, DS_RAND, 1,  95, 0, 1,  95, 0},
  '{3, 0,   0, DS_RAND, 1,   0, 0, 1,   5, 0}, // Same bank on both ports.
  '{3, 0,   0, DS_RAND, 1,  17, 0, 1,  90, 0},
  '{3, 0,   0, DS_RAND, 1,  34, 0, 1,  51, 0},
  '{3, 0,   0, DS_RAND, 1,  68, 0, 1,  95, 0},
  '{3, 0,   0, DS_RAND, 1,  95, 0, 1,  68, 0},
  '{3, 0,   0, DS_RAND, 1,   5, 0, 1,   0, 0},
  '{4, 0,   0, DS_RAND, 1,  17, 0, 0,   0, 0}, // Still in flight when 17 is written.
  '{4, 1,  17, DS_ADDR, 1,  17, 1, 1,  34, 1},
  '{4, 0,   0, DS_RAND, 1,  17, 0, 1,  17, 0},
  '{4, 1,  68, DS_RAND, 1,  68, 1, 1,   0, 1},
  '{4, 0,   0, DS_RAND, 1,  68, 0, 1,  34, 0},
  '{5, 1, 100, DS_RAND, 0,   0, 0, 0,   0, 0},
  '{5, 0,   0, DS_RAND, 1,   0, 0, 1,   5, 0},
  '{5, 0,   0, DS_RAND, 1,  17, 0, 1,  34, 0},
  '{5, 0,   0, DS_RAND, 1,  51, 0, 1,  68, 0},
  '{5, 0,   0, DS_RAND, 1,  90, 0, 1,  95, 0},
  '{5, 0,   0, DS_RAND, 1, 120, 1, 1,  96, 1},
  '{5, 0,   0, DS_RAND, 1, 127, 1, 1,  95, 0}
};

function automatic string test_name(input int id);
  case (id)
    1: return "ready after reset";
    2: return "write then read";
    3: return "simultaneous reads";
    4: return "write priority";
    5: return "out-of-range addresses";
    default: return "unknown";
  endcase
endfunction

`endif

// ==== testbench/dupmem_tb.sv ====
`timescale 1ns/1ps

module dupmem_tb;

  localparam int NUMRDPT    = 2;
  localparam int NUMVBNK    = 6;
  localparam int NUMVROW    = 16;
  localparam int NUMADDR    = 96;
  localparam int SRAM_DELAY = 2;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 5;
  localparam int DW = dupmem_pkg::DATA_W;
  localparam int AW = dupmem_pkg::ADDR_W;
  localparam int BW = dupmem_pkg::BANK_W;
  localparam int RW = dupmem_pkg::ROW_W;
  localparam int PW = dupmem_pkg::PADR_W;

  `include "dupmem_table.svh"

  localparam int WATCHDOG_NS = (NSTEPS + 50) * CLK_PERIOD;

  typedef struct packed {
    int            due; // Negedge count at which the valid must be seen.
    logic [DW-1:0] data;
    logic [PW-1:0] padr;
  } exp_rsp_t;

  logic                clk;
  logic                rst;
  logic                write;
  dupmem_pkg::wr_req_t wreq;
  dupmem_pkg::rd_req_t rreq [NUMRDPT];
  logic                ready;
  dupmem_pkg::rd_rsp_t rrsp [NUMRDPT];

  logic [DW-1:0] shadow [NUMADDR];
  exp_rsp_t      exp_q [NUMRDPT][$];
  logic [15:0]   lfsr;
  logic          ready_exp;
  int            cyc;
  int            errors;
  int            test_err;
  int            tests_ok;
  int            tests_bad;

  always #(CLK_PERIOD / 2) clk = ~clk;

  dupmem_top #(
    .NUMRDPT    (NUMRDPT),
    .NUMVBNK    (NUMVBNK),
    .NUMVROW    (NUMVROW),
    .NUMADDR    (NUMADDR),
    .SRAM_DELAY (SRAM_DELAY)
  ) dut_i (
    .clk   (clk),
    .rst   (rst),
    .write (write),
    .wreq  (wreq),
    .rreq  (rreq),
    .ready (ready),
    .rrsp  (rrsp)
  );

  // Taps 16, 14, 13 and 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_word(output logic [DW-1:0] w);
    for (int i = 0; i < DW; i++) begin
      w[i] = lfsr[15];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic [PW-1:0] phys_addr(input int a);
    logic [BW-1:0] bank;
    logic [RW-1:0] row;
    bank = BW'(a / NUMVROW);
    row  = RW'(a % NUMVROW);
    return {bank, row};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s at cycle %0d: got 0x%0h, expected 0x%0h", name, cyc, got, exp);
      errors++;
      test_err++;
    end
  endtask

  task automatic check_outputs();
    exp_rsp_t e;
    check_val("ready", 32'(ready), 32'(ready_exp));
    for (int p = 0; p < NUMRDPT; p++) begin
      if (exp_q[p].size() > 0 && exp_q[p][0].due == cyc) begin
        e = exp_q[p].pop_front();
        check_val($sformatf("rrsp[%0d].valid", p), 32'(rrsp[p].valid), 32'd1);
        if (rrsp[p].valid === 1'b1) begin
          check_val($sformatf("rrsp[%0d].data", p), 32'(rrsp[p].data), 32'(e.data));
          check_val($sformatf("rrsp[%0d].padr", p), 32'(rrsp[p].padr), 32'(e.padr));
        end
      end else begin
        check_val($sformatf("rrsp[%0d].valid", p), 32'(rrsp[p].valid), 32'd0);
      end
    end
  endtask

  task automatic next_cycle();
    ready_exp = !rst; // The ready register samples !rst on the coming edge.
    @(negedge clk);
    cyc++;
    check_outputs();
  endtask

  task automatic drive_idle();
    write = 1'b0;
    wreq  = '0;
    for (int p = 0; p < NUMRDPT; p++) begin
      rreq[p] = '0;
    end
  endtask

  task automatic drive_row(input int r);
    step_t         s;
    logic [DW-1:0] d;
    logic          wr_ok;
    logic          drop;
    logic          rv [2];
    logic [AW-1:0] ra [2];
    logic          dr [2];
    exp_rsp_t      e;
    s = STEPS[r];
    rv[0] = s.rv0;
    ra[0] = s.ra0;
    dr[0] = s.dr0;
    rv[1] = s.rv1;
    ra[1] = s.ra1;
    dr[1] = s.dr1;
    d = '0;
    if (s.wr && s.dsel == DS_RAND) begin
      rand_word(d);
    end else if (s.wr) begin
      d = {~s.waddr, 2'b10, s.waddr};
    end
    write     = s.wr;
    wreq.addr = s.waddr;
    wreq.data = d;
    wr_ok = ready_exp && s.wr && (s.waddr < NUMADDR);
    for (int p = 0; p < NUMRDPT; p++) begin
      rreq[p].valid = rv[p];
      rreq[p].addr  = ra[p];
      drop = !ready_exp || wr_ok || (ra[p] >= NUMADDR);
      if (rv[p] && drop != dr[p]) begin
        $display("Table row %0d, port %0d: the drop flag disagrees with the access rules.",
                 r, p);
        errors++;
        test_err++;
      end
      if (rv[p] && !dr[p]) begin
        e.due  = cyc + SRAM_DELAY + 1;
        e.data = shadow[ra[p]];
        e.padr = phys_addr(ra[p]);
        exp_q[p].push_back(e);
      end
    end
    if (wr_ok) begin
      shadow[s.waddr] = d;
    end
  endtask

  task automatic finish_test(input int id);
    if (test_err == 0) begin
      tests_ok++;
      $display("[%0d] %s: ok", id, test_name(id));
    end else begin
      tests_bad++;
      $display("[%0d] %s: %0d errors", id, test_name(id), test_err);
    end
    test_err = 0;
  endtask

  initial begin
    logic last;
    clk       = 1'b0;
    rst       = 1'b1;
    lfsr      = 16'd74;
    ready_exp = 1'b0;
    cyc       = 0;
    errors    = 0;
    test_err  = 0;
    tests_ok  = 0;
    tests_bad = 0;
    drive_idle();
    repeat (RST_CYCLES) next_cycle();
    rst = 1'b0;
    for (int r = 0; r < NSTEPS; r++) begin
      if (r > 0) begin
        next_cycle();
      end
      drive_row(r);
      last = (r == NSTEPS - 1);
      if (!last) begin
        last = (STEPS[r+1].test_id != STEPS[r].test_id);
      end
      if (last) begin
        repeat (SRAM_DELAY + 1) begin // Lets every read of the test come back.
          next_cycle();
          drive_idle();
        end
        finish_test(STEPS[r].test_id);
      end
    end
    $display("tests ok: %0d, tests with errors: %0d, errors: %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the table did not complete within %0d ns.", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+testbench
rtl/dupmem_pkg.sv
rtl/np2_addr.sv
rtl/sram_bank.sv
rtl/core_nror1w_dup.sv
rtl/dupmem_top.sv
testbench/dupmem_tb.sv
